/* list.f */
hw/cache_pkg.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_ctrl.sv
hw/main_mem.sv
hw/cache_top.sv
tests/cache_props.sv
tests/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -Wno-fatal \
  -f list.f --top-module cache_tb \
  && ./obj_dir/Vcache_tb \
  || { echo "simulation run reported an error"; exit 1; }

/* tests/cache_tb.sv */
// directed cache tests against a word model; addresses must be word aligned and below 4 KB
`timescale 1ns/1ns

module cache_tb;

  import cache_pkg::*;

  localparam int NUM_LINES   = NUM_LINES_DEF;
  localparam int MEM_LINES   = MEM_LINES_DEF;
  localparam int MEM_LATENCY = MEM_LATENCY_DEF;
  localparam int NUM_WORDS   = MEM_LINES * WORDS_PER_LINE;
  localparam int RAND_REQS   = 200;
  // directed requests, rounded up, plus the random mix
  localparam int NUM_REQS    = 30 + RAND_REQS;
  // worst miss: writeback and refill, plus held responses
  localparam int MISS_BOUND  = 4 * MEM_LATENCY + 8;
  localparam int MAX_CYCLES  = NUM_REQS * MISS_BOUND + 100;

  logic                clk;
  logic                rst_n;
  logic                cachereq_val;
  logic                cachereq_rdy;
  req_type_e           cachereq_type;
  logic [OPAQUE_W-1:0] cachereq_opaque;
  logic [ADDR_W-1:0]   cachereq_addr;
  logic [DATA_W-1:0]   cachereq_data;
  logic                cacheresp_val;
  logic                cacheresp_rdy;
  req_type_e           cacheresp_type;
  logic [OPAQUE_W-1:0] cacheresp_opaque;
  logic [DATA_W-1:0]   cacheresp_data;

  // reference model, one entry per word of backing store
  logic [DATA_W-1:0]    ref_mem [NUM_WORDS];
  // which memory line each cache index holds
  int                   res_line [NUM_LINES];
  logic [NUM_LINES-1:0] res_valid;
  logic [OPAQUE_W-1:0]  next_opaque;
  integer               seed;
  int                   cycle_cnt;

  cache_top #(
    .NUM_LINES   (NUM_LINES),
    .MEM_LINES   (MEM_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_val     (cachereq_val),
    .cachereq_rdy     (cachereq_rdy),
    .cachereq_type    (cachereq_type),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data)
  );

  // handshake assertions on the DUT ports
  bind cache_top cache_props u_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_rdy     (cachereq_rdy),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data)
  );

  always #5 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES)
    begin
      $display("Something failed");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------

  task automatic compare_values(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    if (act !== exp)
    begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("Something failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one request, response held back for hold cycles, lat counts transfer to valid
  task automatic issue_request(input string name, input req_type_e rtype,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input int hold, output logic [DATA_W-1:0] rdata,
                               output int lat);
    logic [OPAQUE_W-1:0] op;
    op = next_opaque;
    next_opaque = next_opaque + 8'd1;
    @(posedge clk);
    cachereq_val    <= 1'b1;
    cachereq_type   <= rtype;
    cachereq_opaque <= op;
    cachereq_addr   <= addr;
    cachereq_data   <= data;
    cacheresp_rdy   <= (hold == 0);
    // request handshake
    @(negedge clk);
    while (!cachereq_rdy)
      @(negedge clk);
    @(posedge clk);
    cachereq_val <= 1'b0;
    lat = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end while (!cacheresp_val);
    rdata = cacheresp_data;
    compare_values({name, " type"}, 32'(rtype), 32'(cacheresp_type));
    compare_values({name, " opaque"}, 32'(op), 32'(cacheresp_opaque));
    // writes answer with zero
    if (rtype != REQ_READ)
      compare_values({name, " write data"}, 32'd0, cacheresp_data);
    // back-pressure, response frozen and no new request taken
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clk);
      if (i == hold - 1)
        cacheresp_rdy <= 1'b1;
      @(negedge clk);
      compare_values({name, " held val"}, 32'd1, 32'(cacheresp_val));
      compare_values({name, " held data"}, rdata, cacheresp_data);
      compare_values({name, " held type"}, 32'(rtype), 32'(cacheresp_type));
      compare_values({name, " held opaque"}, 32'(op), 32'(cacheresp_opaque));
      compare_values({name, " req rdy"}, 32'd0, 32'(cachereq_rdy));
    end
    // response transfers on this edge
    @(posedge clk);
  endtask

  // request plus model check and update
  task automatic access(input string name, input req_type_e rtype,
                        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                        input int hold, output int lat);
    logic [DATA_W-1:0] rdata;
    int                widx;
    int                lidx;
    int                cidx;
    logic              miss;
    widx = (addr >> 2) % NUM_WORDS;
    lidx = widx / WORDS_PER_LINE;
    cidx = lidx % NUM_LINES;
    miss = !res_valid[cidx] || (res_line[cidx] != lidx);
    issue_request(name, rtype, addr, data, hold, rdata, lat);
    if (rtype == REQ_READ)
      compare_values(name, ref_mem[widx], rdata);
    else
    begin
      // write_init miss installs a zeroed line, no refill
      if ((rtype == REQ_WRITE_INIT) && miss)
        for (int w = 0; w < WORDS_PER_LINE; w++)
          ref_mem[lidx * WORDS_PER_LINE + w] = '0;
      ref_mem[widx] = data;
    end
    // every access leaves its line resident
    res_valid[cidx] = 1'b1;
    res_line[cidx]  = lidx;
  endtask

  // ------------------------------------------------
  // directed tests
  // ------------------------------------------------

  task automatic test_hit_timing();
    int lat;
    // first write_init misses, the rest of the line hits
    for (int i = 0; i < WORDS_PER_LINE; i++)
    begin
      access("hit_timing init", REQ_WRITE_INIT, ADDR_W'(4 * i), 32'h1000_0000 + 32'(i), 0, lat);
      if (i > 0)
        compare_values("hit_timing init latency", 32'd2, 32'(lat));
    end
    for (int i = 0; i < WORDS_PER_LINE; i++)
    begin
      access("hit_timing read", REQ_READ, ADDR_W'(4 * i), '0, 0, lat);
      compare_values("hit_timing read latency", 32'd2, 32'(lat));
    end
  endtask

  task automatic test_write_read();
    int lat;
    access("write_read write", REQ_WRITE, 32'h08, 32'hcafe_f00d, 0, lat);
    access("write_read read", REQ_READ, 32'h08, '0, 0, lat);
  endtask

  task automatic test_dirty_evict();
    int lat;
    access("dirty_evict write", REQ_WRITE, 32'h04, 32'h5a5a_1234, 0, lat);
    // same index, other tag
    access("dirty_evict conflict", REQ_READ, 32'h104, '0, 0, lat);
    access("dirty_evict reread", REQ_READ, 32'h04, '0, 0, lat);
  endtask

  task automatic test_unwritten();
    int lat;
    access("unwritten low", REQ_READ, 32'h800, '0, 0, lat);
    access("unwritten high", REQ_READ, 32'hff0, '0, 0, lat);
  endtask

  task automatic test_backpressure();
    int lat;
    access("backpressure write", REQ_WRITE, 32'h0c, 32'h0bad_beef, 4, lat);
    access("backpressure read", REQ_READ, 32'h0c, '0, 6, lat);
  endtask

  task automatic test_random_mix();
    int                lat;
    int                sel;
    int                hold;
    req_type_e         rtype;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    for (int n = 0; n < RAND_REQS; n++)
    begin
      sel  = $unsigned($random(seed)) % 3;
      hold = $unsigned($random(seed)) % 3;
      data = $random(seed);
      // half the time a narrow window, more conflicts and rereads
      if ($random(seed) & 1)
        addr = $random(seed) & 32'h0000_0ffc;
      else
        addr = $random(seed) & 32'h0000_03fc;
      if (sel == 0)
        rtype = REQ_READ;
      else if (sel == 1)
        rtype = REQ_WRITE;
      else
        rtype = REQ_WRITE_INIT;
      access("random_mix", rtype, addr, data, hold, lat);
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    cachereq_val    = 1'b0;
    cachereq_type   = REQ_READ;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cacheresp_rdy   = 1'b1;
    seed            = 32'hbb42_ecbe;
    next_opaque     = '0;
    cycle_cnt       = 0;
    res_valid       = '0;
    for (int i = 0; i < NUM_WORDS; i++)
      ref_mem[i] = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_hit_timing();
    test_write_read();
    test_dirty_evict();
    test_unwritten();
    test_backpressure();
    test_random_mix();
    $display("Everything OK");
    $finish;
  end

endmodule

/* tests/cache_props.sv */
// handshake assertions for cache_top, bound from the testbench; checks off during reset but one
`timescale 1ns/1ns

module cache_props (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           cachereq_rdy,
  input logic                           cacheresp_val,
  input logic                           cacheresp_rdy,
  input cache_pkg::req_type_e           cacheresp_type,
  input logic [cache_pkg::OPAQUE_W-1:0] cacheresp_opaque,
  input logic [cache_pkg::DATA_W-1:0]   cacheresp_data
);

  // ------------------------------------------------
  // response channel
  // ------------------------------------------------

  // blocking cache, nothing accepted while a response waits
  resp_blocks_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    cacheresp_val |-> !cachereq_rdy
  ) else $error("cachereq_rdy high while a response is pending");

  // stalled response keeps its fields
  resp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cacheresp_val && !cacheresp_rdy) |=>
      (cacheresp_val && $stable(cacheresp_type) && $stable(cacheresp_opaque)
       && $stable(cacheresp_data))
  ) else $error("response dropped or changed while stalled");

  // no response straight out of reset
  resp_idle_after_reset: assert property (
    @(posedge clk)
    !rst_n |=> !cacheresp_val
  ) else $error("cacheresp_val high in the cycle after reset");

endmodule

/* hw/cache_top.sv */
// cache plus backing memory; memory starts cleared and responds after a fixed MEM_LATENCY
`timescale 1ns/1ns

module cache_top #(
  parameter int NUM_LINES   = cache_pkg::NUM_LINES_DEF,
  parameter int MEM_LINES   = cache_pkg::MEM_LINES_DEF,
  parameter int MEM_LATENCY = cache_pkg::MEM_LATENCY_DEF
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cachereq_val,
  output logic                           cachereq_rdy,
  input  cache_pkg::req_type_e           cachereq_type,
  input  logic [cache_pkg::OPAQUE_W-1:0] cachereq_opaque,
  input  logic [cache_pkg::ADDR_W-1:0]   cachereq_addr,
  input  logic [cache_pkg::DATA_W-1:0]   cachereq_data,
  output logic                           cacheresp_val,
  input  logic                           cacheresp_rdy,
  output cache_pkg::req_type_e           cacheresp_type,
  output logic [cache_pkg::OPAQUE_W-1:0] cacheresp_opaque,
  output logic [cache_pkg::DATA_W-1:0]   cacheresp_data
);

  import cache_pkg::*;

  // ------------------------------------------------
  // controller to memory
  // ------------------------------------------------

  logic                       memreq_val;
  logic                       memreq_rdy;
  logic                       memreq_write;
  logic [ADDR_W-OFFSET_W-1:0] memreq_addr;
  logic [LINE_W-1:0]          memreq_data;
  logic                       memresp_val;
  logic                       memresp_rdy;
  logic [LINE_W-1:0]          memresp_data;

  // controller to arrays
  logic                       hit;
  logic                       victim_dirty;
  logic [ADDR_W-OFFSET_W-1:0] victim_line_addr;
  logic [LINE_W-1:0]          line_rdata;
  logic                       tag_we;
  logic                       set_dirty;
  logic                       line_we;
  logic [LINE_W-1:0]          line_wdata;
  logic                       word_we;
  logic [DATA_W-1:0]          word_wdata;
  logic [ADDR_W-1:0]          lookup_addr;

  cache_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_val     (cachereq_val),
    .cachereq_rdy     (cachereq_rdy),
    .cachereq_type    (cachereq_type),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data),
    .memreq_val       (memreq_val),
    .memreq_rdy       (memreq_rdy),
    .memreq_write     (memreq_write),
    .memreq_addr      (memreq_addr),
    .memreq_data      (memreq_data),
    .memresp_val      (memresp_val),
    .memresp_rdy      (memresp_rdy),
    .memresp_data     (memresp_data),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .victim_line_addr (victim_line_addr),
    .line_rdata       (line_rdata),
    .tag_we           (tag_we),
    .set_dirty        (set_dirty),
    .line_we          (line_we),
    .line_wdata       (line_wdata),
    .word_we          (word_we),
    .word_wdata       (word_wdata),
    .lookup_addr      (lookup_addr)
  );

  // tags and data indexed by the latched address
  cache_tag_array #(
    .NUM_LINES (NUM_LINES)
  ) u_tags (
    .clk              (clk),
    .rst_n            (rst_n),
    .lookup_addr      (lookup_addr),
    .tag_we           (tag_we),
    .set_dirty        (set_dirty),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .victim_line_addr (victim_line_addr)
  );

  cache_data_array #(
    .NUM_LINES (NUM_LINES)
  ) u_data (
    .clk        (clk),
    .index_addr (lookup_addr),
    .line_we    (line_we),
    .line_wdata (line_wdata),
    .word_we    (word_we),
    .word_wdata (word_wdata),
    .line_rdata (line_rdata)
  );

  main_mem #(
    .MEM_LINES   (MEM_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_write (memreq_write),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_data (memresp_data)
  );

endmodule

/* hw/main_mem.sv */
// line-wide backing store, cleared on reset; fixed latency >= 1, one request outstanding at a time
`timescale 1ns/1ns

module main_mem #(
  parameter int MEM_LINES   = cache_pkg::MEM_LINES_DEF,
  parameter int MEM_LATENCY = cache_pkg::MEM_LATENCY_DEF
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             memreq_val,
  output logic                                             memreq_rdy,
  input  logic                                             memreq_write,
  input  logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-1:0] memreq_addr,
  input  logic [cache_pkg::LINE_W-1:0]                     memreq_data,
  output logic                                             memresp_val,
  input  logic                                             memresp_rdy,
  output logic [cache_pkg::LINE_W-1:0]                     memresp_data
);

  import cache_pkg::*;

  localparam int IDX_W = $clog2(MEM_LINES);
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  logic [LINE_W-1:0] mem [MEM_LINES];

  logic              busy_q;
  logic              resp_val_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [LINE_W-1:0] resp_data_q;
  logic [IDX_W-1:0]  idx;
  logic              req_fire;

  // upper line address bits fall off
  assign idx      = memreq_addr[IDX_W-1:0];
  assign req_fire = memreq_val && memreq_rdy;

  assign memreq_rdy   = !busy_q;
  assign memresp_val  = resp_val_q;
  assign memresp_data = resp_data_q;

  // storage, write takes effect at request transfer
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < MEM_LINES; i++)
        mem[i] <= '0;
    end
    else if (req_fire && memreq_write)
      mem[idx] <= memreq_data;
  end

  // ------------------------------------------------
  // latency counter
  // ------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy_q     <= 1'b0;
      resp_val_q <= 1'b0;
      cnt_q      <= '0;
    end
    else if (req_fire)
    begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(MEM_LATENCY - 1);
    end
    else if (resp_val_q)
    begin
      // hold until the controller takes it
      if (memresp_rdy)
      begin
        resp_val_q <= 1'b0;
        busy_q     <= 1'b0;
      end
    end
    else if (busy_q)
    begin
      if (cnt_q == '0)
        resp_val_q <= 1'b1;
      else
        cnt_q <= cnt_q - 1'b1;
    end
  end

  // read data captured at transfer, write ack carries zero
  always_ff @(posedge clk)
  begin
    if (req_fire)
      resp_data_q <= memreq_write ? '0 : mem[idx];
  end

endmodule

/* hw/cache_ctrl.sv */
// blocking cache FSM; one request in flight, hits respond 2 cycles after transfer, misses vary
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                                             clk,
  input  logic                                             rst_n,
  // request channel
  input  logic                                             cachereq_val,
  output logic                                             cachereq_rdy,
  input  cache_pkg::req_type_e                             cachereq_type,
  input  logic [cache_pkg::OPAQUE_W-1:0]                   cachereq_opaque,
  input  logic [cache_pkg::ADDR_W-1:0]                     cachereq_addr,
  input  logic [cache_pkg::DATA_W-1:0]                     cachereq_data,
  // response channel
  output logic                                             cacheresp_val,
  input  logic                                             cacheresp_rdy,
  output cache_pkg::req_type_e                             cacheresp_type,
  output logic [cache_pkg::OPAQUE_W-1:0]                   cacheresp_opaque,
  output logic [cache_pkg::DATA_W-1:0]                     cacheresp_data,
  // memory port
  output logic                                             memreq_val,
  input  logic                                             memreq_rdy,
  output logic                                             memreq_write,
  output logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-1:0] memreq_addr,
  output logic [cache_pkg::LINE_W-1:0]                     memreq_data,
  input  logic                                             memresp_val,
  output logic                                             memresp_rdy,
  input  logic [cache_pkg::LINE_W-1:0]                     memresp_data,
  // arrays
  input  logic                                             hit,
  input  logic                                             victim_dirty,
  input  logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-1:0] victim_line_addr,
  input  logic [cache_pkg::LINE_W-1:0]                     line_rdata,
  output logic                                             tag_we,
  output logic                                             set_dirty,
  output logic                                             line_we,
  output logic [cache_pkg::LINE_W-1:0]                     line_wdata,
  output logic                                             word_we,
  output logic [cache_pkg::DATA_W-1:0]                     word_wdata,
  output logic [cache_pkg::ADDR_W-1:0]                     lookup_addr
);

  import cache_pkg::*;

  localparam int SEL_W = $clog2(WORDS_PER_LINE);

  ctrl_state_e state_q;
  ctrl_state_e state_nxt;

  // latched request
  req_type_e           req_type_q;
  logic [OPAQUE_W-1:0] req_opaque_q;
  logic [ADDR_W-1:0]   req_addr_q;
  logic [DATA_W-1:0]   req_data_q;
  // line to install in ST_UPDATE
  logic [LINE_W-1:0]   fill_line_q;

  logic             is_store;
  logic             hit_store;
  logic [SEL_W-1:0] word_sel;

  // write and write_init both modify the line
  assign is_store  = (req_type_q != REQ_READ);
  assign hit_store = (state_q == ST_TAG_CHECK) && hit && is_store;
  assign word_sel  = req_addr_q[OFFSET_W-1 -: SEL_W];

  // ------------------------------------------------
  // state and request registers
  // ------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_nxt;
  end

  always_ff @(posedge clk)
  begin
    if (cachereq_val && cachereq_rdy)
    begin
      req_type_q   <= cachereq_type;
      req_opaque_q <= cachereq_opaque;
      req_addr_q   <= cachereq_addr;
      req_data_q   <= cachereq_data;
    end
    // zero line for write_init, replaced by refill data otherwise
    if (state_q == ST_TAG_CHECK)
      fill_line_q <= '0;
    else if ((state_q == ST_REFILL_WAIT) && memresp_val)
      fill_line_q <= memresp_data;
  end

  // ------------------------------------------------
  // next state
  // ------------------------------------------------

  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE:
        if (cachereq_val)
          state_nxt = ST_TAG_CHECK;
      ST_TAG_CHECK:
        // a store hit writes here, so the response follows at once
        if (hit)
          state_nxt = ST_RESP;
        else if (victim_dirty)
          state_nxt = ST_WB_REQ;
        else if (req_type_q == REQ_WRITE_INIT)
          state_nxt = ST_UPDATE;
        else
          state_nxt = ST_REFILL_REQ;
      ST_WB_REQ:
        if (memreq_rdy)
          state_nxt = ST_WB_WAIT;
      ST_WB_WAIT:
        // write ack from memory
        if (memresp_val)
          state_nxt = (req_type_q == REQ_WRITE_INIT) ? ST_UPDATE : ST_REFILL_REQ;
      ST_REFILL_REQ:
        if (memreq_rdy)
          state_nxt = ST_REFILL_WAIT;
      ST_REFILL_WAIT:
        if (memresp_val)
          state_nxt = ST_UPDATE;
      ST_UPDATE:
        state_nxt = ST_RESP;
      ST_RESP:
        if (cacheresp_rdy)
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  // ------------------------------------------------
  // outputs
  // ------------------------------------------------

  // blocking: only idle takes a request
  assign cachereq_rdy     = (state_q == ST_IDLE);
  assign cacheresp_val    = (state_q == ST_RESP);
  assign cacheresp_type   = req_type_q;
  assign cacheresp_opaque = req_opaque_q;
  // writes answer with zero data
  assign cacheresp_data   = (req_type_q == REQ_READ) ?
                            line_rdata[word_sel*DATA_W +: DATA_W] : '0;

  // memory side, writeback uses the victim address
  assign memreq_val   = (state_q == ST_WB_REQ) || (state_q == ST_REFILL_REQ);
  assign memreq_write = (state_q == ST_WB_REQ);
  assign memreq_addr  = memreq_write ? victim_line_addr : req_addr_q[ADDR_W-1:OFFSET_W];
  assign memreq_data  = line_rdata;
  assign memresp_rdy  = (state_q == ST_WB_WAIT) || (state_q == ST_REFILL_WAIT);

  // array updates
  assign lookup_addr = req_addr_q;
  assign line_we     = (state_q == ST_UPDATE);
  assign line_wdata  = fill_line_q;
  assign word_we     = hit_store || (line_we && is_store);
  assign word_wdata  = req_data_q;
  assign tag_we      = hit_store || line_we;
  assign set_dirty   = is_store;

endmodule

/* hw/cache_data_array.sv */
// line-wide data store, unreset; byte offset bits 1:0 are ignored since writes are whole words
`timescale 1ns/1ns

module cache_data_array #(
  parameter int NUM_LINES = cache_pkg::NUM_LINES_DEF
) (
  input  logic                         clk,
  input  logic [cache_pkg::ADDR_W-1:0] index_addr,
  input  logic                         line_we,
  input  logic [cache_pkg::LINE_W-1:0] line_wdata,
  input  logic                         word_we,
  input  logic [cache_pkg::DATA_W-1:0] word_wdata,
  output logic [cache_pkg::LINE_W-1:0] line_rdata
);

  import cache_pkg::*;

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int SEL_W = $clog2(WORDS_PER_LINE);

  logic [LINE_W-1:0] data_mem [NUM_LINES];

  logic [IDX_W-1:0]  idx;
  logic [SEL_W-1:0]  word_sel;
  logic [LINE_W-1:0] wline;

  assign idx      = index_addr[OFFSET_W +: IDX_W];
  // word within the line
  assign word_sel = index_addr[OFFSET_W-1 -: SEL_W];

  // async read of the indexed line
  assign line_rdata = data_mem[idx];

  // ------------------------------------------------
  // write merge
  // ------------------------------------------------

  // start from the fill line or the stored one,
  // then overlay the single word if asked
  always_comb
  begin
    wline = line_we ? line_wdata : data_mem[idx];
    if (word_we)
      wline[word_sel*DATA_W +: DATA_W] = word_wdata;
  end

  always_ff @(posedge clk)
  begin
    if (line_we || word_we)
      data_mem[idx] <= wline;
  end

endmodule

/* hw/cache_tag_array.sv */
// direct-mapped tag store; NUM_LINES must be a power of two, tags are not reset, only valid and dirty
`timescale 1ns/1ns

module cache_tag_array #(
  parameter int NUM_LINES = cache_pkg::NUM_LINES_DEF
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [cache_pkg::ADDR_W-1:0]                 lookup_addr,
  input  logic                                         tag_we,
  input  logic                                         set_dirty,
  output logic                                         hit,
  output logic                                         victim_dirty,
  output logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-1:0] victim_line_addr
);

  import cache_pkg::*;

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

  // per-line state
  logic [NUM_LINES-1:0] valid_q;
  logic [NUM_LINES-1:0] dirty_q;
  logic [TAG_W-1:0]     tag_mem [NUM_LINES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;

  // split the address: tag | index | offset
  assign idx = lookup_addr[OFFSET_W +: IDX_W];
  assign tag = lookup_addr[ADDR_W-1 -: TAG_W];

  // combinational lookup
  assign hit          = valid_q[idx] && (tag_mem[idx] == tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  // rebuild the resident line's address for writeback
  assign victim_line_addr = {tag_mem[idx], idx};

  // valid and dirty bits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (tag_we)
    begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= set_dirty;
    end
  end

  // tag storage
  always_ff @(posedge clk)
  begin
    if (tag_we)
      tag_mem[idx] <= tag;
  end

endmodule

/* hw/cache_pkg.sv */
// shared cache constants; line count must be a power of two and only full 32-bit words are supported
package cache_pkg;

  // ------------------------------------------------
  // geometry
  // ------------------------------------------------

  // byte address and word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // one cache line is also one memory word
  localparam int LINE_W = 128;
  // request tag echoed back in the response
  localparam int OPAQUE_W = 8;

  localparam int WORDS_PER_LINE = LINE_W / DATA_W;
  // byte offset inside a 16-byte line
  localparam int OFFSET_W = 4;

  // 16 lines of 16 bytes, 256 bytes in all
  localparam int NUM_LINES_DEF = 16;
  // 4 KB of backing store
  localparam int MEM_LINES_DEF = 256;
  // cycles from memory request transfer to response valid
  localparam int MEM_LATENCY_DEF = 3;

  // ------------------------------------------------
  // encodings
  // ------------------------------------------------

  // request type, echoed as the response type
  typedef enum logic [1:0] {
    REQ_READ       = 2'd0,
    REQ_WRITE      = 2'd1,
    REQ_WRITE_INIT = 2'd2
  } req_type_e;

  // controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_WB_REQ,
    ST_WB_WAIT,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_UPDATE,
    ST_RESP
  } ctrl_state_e;

endpackage
